// ==== verilog.f ====
+incdir+.
rowdec_pkg.sv
credit_if.sv
ptr_ingress.sv
ptr_fifo.sv
row_decoder.sv
rowdec_top.sv
tb_rowdec.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_rowdec -f verilog.f \
    -o sim_rowdec > sim.log 2>&1 \
    && ./obj_dir/sim_rowdec >> sim.log 2>&1
grep -q "TEST PASSED" sim.log && echo "Simulation passed, see sim.log" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== tb_rowdec.sv ====
`default_nettype none

`include "rowdec_params.svh"

module tb_rowdec;

    localparam int LANES     = `ROWDEC_LANES;
    localparam int ROW_W     = `ROWDEC_ROW_W;
    localparam int CLK_HALF  = 20;
    localparam int DRV_DLY   = 5;       // Input drive offset after the rising edge
    localparam int NUM_TESTS = 5;
    localparam int MAX_HELD  = `ROWDEC_FIFO_DEPTH + `ROWDEC_DEC_SLOTS + 1;

    logic                   clk;
    logic                   rst_n;
    logic                   ptr_valid;
    logic                   ptr_ready;
    rowdec_pkg::ptr_t       ptr_data;
    logic                   ptr_last;
    logic                   ids_valid;
    logic                   ids_ready;
    rowdec_pkg::id_beat_t   ids_data;
    rowdec_pkg::lane_mask_t ids_mask;
    logic                   ids_last;

    rowdec_pkg::ptr_t       mat_ptrs [$];   // Matrix being built by a test
    rowdec_pkg::id_beat_t   exp_data [$];
    rowdec_pkg::lane_mask_t exp_mask [$];
    logic                   exp_last [$];

    string  cur_test;
    logic   ready_random;
    logic   ready_level;
    int     mon_errors    = 0;
    int     flow_errors;
    int     beats_checked = 0;
    int     cycle_cnt     = 0;
    int     cycle_limit   = NUM_TESTS * 200;   // Grows with every matrix loaded

    rowdec_top u_rowdec_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .ptr_valid  (ptr_valid),
        .ptr_ready  (ptr_ready),
        .ptr_data   (ptr_data),
        .ptr_last   (ptr_last),
        .ids_valid  (ids_valid),
        .ids_ready  (ids_ready),
        .ids_data   (ids_data),
        .ids_mask   (ids_mask),
        .ids_last   (ids_last)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #CLK_HALF clk = ~clk;
        end
    end

    // Output ready is held or random per cycle
    initial
    begin
        ids_ready = 1'b0;
        forever
        begin
            @(posedge clk);
            #DRV_DLY;
            ids_ready = ready_random ? 1'($urandom_range(0, 1)) : ready_level;
        end
    end

    // Expected beats for the matrix in mat_ptrs
    function automatic void load_expected();
        int                     n;
        int                     d;
        int                     take;
        int                     ids;
        rowdec_pkg::id_beat_t   data;
        rowdec_pkg::lane_mask_t mask;
        n   = mat_ptrs.size();
        ids = 0;
        for (int row = 0; row < n - 1; row++)
        begin
            d = int'(mat_ptrs[row + 1]) - int'(mat_ptrs[row]);
            while (d > 0)
            begin
                take = (d > LANES) ? LANES : d;
                d    = d - take;
                data = '0;
                mask = '0;
                for (int k = 0; k < take; k++)
                begin
                    data[k*ROW_W +: ROW_W] = rowdec_pkg::row_id_t'(row);
                    mask[k]                = 1'b1;
                end
                exp_data.push_back(data);
                exp_mask.push_back(mask);
                exp_last.push_back((row == n - 2) && (d == 0));
                ids = ids + take;
            end
        end
        // Empty final row or no rows at all
        if (n == 1 || mat_ptrs[n - 1] == mat_ptrs[n - 2])
        begin
            exp_data.push_back('0);
            exp_mask.push_back('0);
            exp_last.push_back(1'b1);
        end
        cycle_limit = cycle_limit + n * 8 + ids;
    endfunction

    function automatic void check_beat();
        rowdec_pkg::id_beat_t   want_data;
        rowdec_pkg::lane_mask_t want_mask;
        logic                   want_last;
        rowdec_pkg::row_id_t    want_id;
        rowdec_pkg::row_id_t    got_id;
        assert (exp_mask.size() != 0)
        else
        begin
            mon_errors++;
            $display("Output beat arrived in %s with no beat expected", cur_test);
        end
        if (exp_mask.size() == 0)
        begin
            return;
        end
        want_data = exp_data.pop_front();
        want_mask = exp_mask.pop_front();
        want_last = exp_last.pop_front();
        assert (ids_mask == want_mask)
        else
        begin
            mon_errors++;
            $display("Fail %s: mask expected %b, actual %b", cur_test, want_mask, ids_mask);
        end
        assert (ids_last == want_last)
        else
        begin
            mon_errors++;
            $display("Fail %s: last expected %b, actual %b", cur_test, want_last, ids_last);
        end
        for (int k = 0; k < LANES; k++)
        begin
            want_id = want_data[k*ROW_W +: ROW_W];
            got_id  = ids_data[k*ROW_W +: ROW_W];
            if (want_mask[k])   // Lanes above the mask carry no id
            begin
                assert (got_id == want_id)
                else
                begin
                    mon_errors++;
                    $display("Fail %s: lane %0d id expected %0d, actual %0d",
                             cur_test, k, want_id, got_id);
                end
            end
        end
        beats_checked++;
    endfunction

    // Sampled mid-cycle for the transfer at the next rising edge
    always @(negedge clk)
    begin
        if (rst_n && ids_valid && ids_ready)
        begin
            check_beat();
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
        begin
            $display("Timeout in %s after %0d cycles, the output stream stopped",
                     cur_test, cycle_cnt);
            $display("Summary: %0d errors, %0d beats checked",
                     mon_errors + flow_errors + 1, beats_checked);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic push_ptr(input rowdec_pkg::ptr_t p, input logic l);
        ptr_valid = 1'b1;
        ptr_data  = p;
        ptr_last  = l;
        @(negedge clk);
        while (!ptr_ready)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRV_DLY;
        ptr_valid = 1'b0;
    endtask

    // Mode changes mid-cycle and takes effect at the next edge
    task automatic set_ready(input logic rnd, input logic level);
        @(negedge clk);
        ready_random = rnd;
        ready_level  = level;
        @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic send_matrix();
        load_expected();
        for (int i = 0; i < mat_ptrs.size(); i++)
        begin
            push_ptr(mat_ptrs[i], i == mat_ptrs.size() - 1);
        end
    endtask

    task automatic wait_drain();
        while (exp_mask.size() != 0)
        begin
            @(posedge clk);
            #DRV_DLY;
        end
    endtask

    task automatic basic_decode();
        cur_test = "basic_decode";
        mat_ptrs = '{0, 3, 3, 9, 10};
        send_matrix();
        wait_drain();
    endtask

    task automatic empty_endings();
        cur_test = "empty_endings";
        mat_ptrs = '{5, 7, 7};
        send_matrix();
        mat_ptrs = '{4};        // Lone pointer with no rows
        send_matrix();
        wait_drain();
    endtask

    task automatic random_backpressure();
        int base;
        int rows;
        cur_test = "random_backpressure";
        set_ready(1'b1, 1'b1);
        repeat (6)
        begin
            rows = $urandom_range(0, 7);
            base = $urandom_range(0, 500);
            mat_ptrs.delete();
            mat_ptrs.push_back(rowdec_pkg::ptr_t'(base));
            for (int r = 0; r < rows; r++)
            begin
                base = base + $urandom_range(0, 9);
                mat_ptrs.push_back(rowdec_pkg::ptr_t'(base));
            end
            send_matrix();
        end
        wait_drain();
        set_ready(1'b0, 1'b1);
    endtask

    task automatic back_to_back();
        cur_test = "back_to_back";
        mat_ptrs = '{100, 102, 107, 107, 111};
        send_matrix();
        mat_ptrs = '{40, 41, 49, 58};   // Lower base and ids start over
        send_matrix();
        wait_drain();
    endtask

    task automatic credit_limit();
        int   idx;
        logic ready_seen;
        cur_test = "credit_limit";
        mat_ptrs.delete();
        for (int i = 0; i < 16; i++)
        begin
            mat_ptrs.push_back(rowdec_pkg::ptr_t'(i * 3));
        end
        load_expected();
        set_ready(1'b0, 1'b0);
        idx        = 0;
        ready_seen = 1'b1;
        ptr_valid  = 1'b1;
        ptr_data   = mat_ptrs[0];
        ptr_last   = 1'b0;
        // Offer pointers against a stalled output
        repeat (40)
        begin
            @(negedge clk);
            ready_seen = ptr_ready && ptr_valid;
            @(posedge clk);
            #DRV_DLY;
            if (ready_seen)
            begin
                idx++;
                if (idx < mat_ptrs.size())
                begin
                    ptr_data = mat_ptrs[idx];
                    ptr_last = (idx == mat_ptrs.size() - 1);
                end
                else
                begin
                    ptr_valid = 1'b0;
                end
            end
        end
        ptr_valid = 1'b0;
        assert (idx <= MAX_HELD)
        else
        begin
            flow_errors++;
            $display("Fail credit_limit: accepted expected at most %0d, actual %0d",
                     MAX_HELD, idx);
        end
        assert (!ptr_ready)
        else
        begin
            flow_errors++;
            $display("ptr_ready stayed high in credit_limit while the output was stalled");
        end
        set_ready(1'b0, 1'b1);
        while (idx < mat_ptrs.size())
        begin
            push_ptr(mat_ptrs[idx], idx == mat_ptrs.size() - 1);
            idx++;
        end
        wait_drain();
    endtask

    initial
    begin
        void'($urandom(32'hc2ce_b2d9));
        rst_n        = 1'b0;
        ptr_valid    = 1'b0;
        ptr_data     = '0;
        ptr_last     = 1'b0;
        ready_random = 1'b0;
        ready_level  = 1'b1;
        flow_errors  = 0;
        cur_test     = "reset";
        repeat (5)
        begin
            @(posedge clk);
        end
        #DRV_DLY;
        rst_n = 1'b1;

        basic_decode();
        empty_endings();
        random_backpressure();
        back_to_back();
        credit_limit();

        // Quiet period to catch stray beats
        repeat (20)
        begin
            @(posedge clk);
        end

        $display("Summary: %0d errors, %0d beats checked",
                 mon_errors + flow_errors, beats_checked);
        if (mon_errors + flow_errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rowdec_top.sv ====
`default_nettype none

`include "rowdec_params.svh"

module rowdec_top (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    ptr_valid,
    output logic                    ptr_ready,
    input  rowdec_pkg::ptr_t        ptr_data,
    input  logic                    ptr_last,

    output logic                    ids_valid,
    input  logic                    ids_ready,
    output rowdec_pkg::id_beat_t    ids_data,
    output rowdec_pkg::lane_mask_t  ids_mask,
    output logic                    ids_last
);

    credit_if ing_link ();      // Ingress to buffer
    credit_if dec_link ();      // Buffer to decoder

    ptr_ingress #(
        .CREDITS        (`ROWDEC_FIFO_DEPTH)
    ) u_ingress (
        .clk            (clk),
        .rst_n          (rst_n),
        .ptr_valid      (ptr_valid),
        .ptr_ready      (ptr_ready),
        .ptr_data       (ptr_data),
        .ptr_last       (ptr_last),
        .link           (ing_link.sender)
    );

    ptr_fifo #(
        .DEPTH          (`ROWDEC_FIFO_DEPTH),
        .OUT_CREDITS    (`ROWDEC_DEC_SLOTS)
    ) u_fifo (
        .clk            (clk),
        .rst_n          (rst_n),
        .up             (ing_link.receiver),
        .down           (dec_link.sender)
    );

    row_decoder u_decoder (
        .clk            (clk),
        .rst_n          (rst_n),
        .link           (dec_link.receiver),
        .ids_valid      (ids_valid),
        .ids_ready      (ids_ready),
        .ids_data       (ids_data),
        .ids_mask       (ids_mask),
        .ids_last       (ids_last)
    );

endmodule

`default_nettype wire

// ==== row_decoder.sv ====
`default_nettype none

`include "rowdec_params.svh"

module row_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    credit_if.receiver              link,
    output logic                    ids_valid,
    input  logic                    ids_ready,
    output rowdec_pkg::id_beat_t    ids_data,
    output rowdec_pkg::lane_mask_t  ids_mask,
    output logic                    ids_last
);

    localparam int SLOTS   = `ROWDEC_DEC_SLOTS;
    localparam int LANES   = `ROWDEC_LANES;
    localparam int SLOT_AW = (SLOTS > 1) ? $clog2(SLOTS) : 1;
    localparam int CNT_W   = $clog2(SLOTS + 1);
    localparam rowdec_pkg::ptr_t LANES_P = rowdec_pkg::ptr_t'(LANES);

    rowdec_pkg::ptr_t       slot_ptr  [SLOTS];
    logic                   slot_last [SLOTS];
    logic [SLOT_AW-1:0]     wr_idx;
    logic [SLOT_AW-1:0]     rd_idx;
    logic [CNT_W-1:0]       slot_cnt;

    rowdec_pkg::dec_state_t state;
    rowdec_pkg::ptr_t       prev_ptr;       // Opening pointer of the current row
    rowdec_pkg::ptr_t       remaining;      // Ids of the row still to send
    rowdec_pkg::row_id_t    row_id;

    logic                   head_vld;
    rowdec_pkg::ptr_t       head_ptr;
    logic                   head_last;
    rowdec_pkg::ptr_t       row_len;
    logic                   beat_fire;
    logic                   last_beat;
    logic                   pop;

    assign head_vld  = (slot_cnt != '0);
    assign head_ptr  = slot_ptr[rd_idx];
    assign head_last = slot_last[rd_idx];
    assign row_len   = head_ptr - prev_ptr;
    assign beat_fire = ids_valid && ids_ready;
    assign last_beat = (remaining <= LANES_P);

    // Closing pointer stays in its slot until its row is fully sent
    always_comb
    begin
        pop = 1'b0;
        case (state)
            rowdec_pkg::DEC_START: pop = head_vld && !head_last;
            rowdec_pkg::DEC_WAIT:  pop = head_vld && (row_len == '0) && !head_last;
            rowdec_pkg::DEC_EMIT:  pop = beat_fire && last_beat;
            default:               pop = 1'b0;
        endcase
    end

    assign ids_valid = (state == rowdec_pkg::DEC_EMIT);
    assign ids_last  = head_last && last_beat;
    assign ids_data  = {LANES{row_id}};     // Lanes above the mask are don't care

    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            ids_mask[i] = (remaining > rowdec_pkg::ptr_t'(i));
        end
    end

    always_ff @(posedge clk)
    begin
        if (link.valid)
        begin
            slot_ptr[wr_idx]  <= link.ptr;
            slot_last[wr_idx] <= link.last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_idx      <= '0;
            rd_idx      <= '0;
            slot_cnt    <= '0;
            link.credit <= 1'b0;
            state       <= rowdec_pkg::DEC_START;
            remaining   <= '0;
            row_id      <= '0;
        end
        else
        begin
            if (link.valid)
            begin
                wr_idx <= (wr_idx == SLOT_AW'(SLOTS - 1)) ? '0 : wr_idx + 1'b1;
            end
            if (pop)
            begin
                rd_idx <= (rd_idx == SLOT_AW'(SLOTS - 1)) ? '0 : rd_idx + 1'b1;
            end
            slot_cnt    <= slot_cnt + CNT_W'(link.valid) - CNT_W'(pop);
            link.credit <= pop;     // Retired slot goes back to the buffer

            case (state)
                rowdec_pkg::DEC_START:
                begin
                    if (head_vld)
                    begin
                        prev_ptr  <= head_ptr;
                        remaining <= '0;    // Lone last pointer gives an empty last beat
                        state     <= head_last ? rowdec_pkg::DEC_EMIT : rowdec_pkg::DEC_WAIT;
                    end
                end
                rowdec_pkg::DEC_WAIT:
                begin
                    if (head_vld)
                    begin
                        if (row_len != '0 || head_last)
                        begin
                            remaining <= row_len;
                            state     <= rowdec_pkg::DEC_EMIT;
                        end
                        else
                        begin
                            prev_ptr <= head_ptr;   // Empty row is skipped
                            row_id   <= row_id + rowdec_pkg::row_id_t'(1);
                        end
                    end
                end
                rowdec_pkg::DEC_EMIT:
                begin
                    if (beat_fire)
                    begin
                        if (last_beat)
                        begin
                            prev_ptr  <= head_ptr;
                            remaining <= '0;
                            if (head_last)
                            begin
                                row_id <= '0;
                                state  <= rowdec_pkg::DEC_START;
                            end
                            else
                            begin
                                row_id <= row_id + rowdec_pkg::row_id_t'(1);
                                state  <= rowdec_pkg::DEC_WAIT;
                            end
                        end
                        else
                        begin
                            remaining <= remaining - LANES_P;
                        end
                    end
                end
                default: state <= rowdec_pkg::DEC_START;
            endcase
        end
    end

    // Row pointers of one matrix never go backwards
    a_ptr_monotonic: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == rowdec_pkg::DEC_WAIT && head_vld) |-> (head_ptr >= prev_ptr)
    ) else $error("row_decoder: row pointer decreased within a matrix");

    a_stall_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ids_valid && !ids_ready) |=>
            (ids_valid && $stable(ids_data) && $stable(ids_mask) && $stable(ids_last))
    ) else $error("row_decoder: output changed under a stall");

endmodule

`default_nettype wire

// ==== ptr_fifo.sv ====
`default_nettype none

module ptr_fifo #(
    parameter int DEPTH       = 8,
    parameter int OUT_CREDITS = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    credit_if.receiver  up,
    credit_if.sender    down
);

    localparam int AW      = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W   = $clog2(DEPTH + 1);
    localparam int CRED_W  = $clog2(OUT_CREDITS + 1);

    rowdec_pkg::ptr_t   mem_ptr  [DEPTH];
    logic               mem_last [DEPTH];

    logic [AW-1:0]      wr_idx;
    logic [AW-1:0]      rd_idx;
    logic [CNT_W-1:0]   count;
    logic [CRED_W-1:0]  out_cnt;        // Downstream credits held

    logic               avail;
    logic               send;
    rowdec_pkg::ptr_t   head_ptr;
    logic               head_last;

    // An entry pushed this cycle may leave at once through the bypass
    assign avail     = (count != '0) || up.valid;
    assign send      = avail && (out_cnt != '0);
    assign head_ptr  = (count == '0) ? up.ptr  : mem_ptr[rd_idx];
    assign head_last = (count == '0) ? up.last : mem_last[rd_idx];

    always_ff @(posedge clk)
    begin
        if (up.valid)
        begin
            mem_ptr[wr_idx]  <= up.ptr;
            mem_last[wr_idx] <= up.last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_idx     <= '0;
            rd_idx     <= '0;
            count      <= '0;
            out_cnt    <= CRED_W'(OUT_CREDITS);
            down.valid <= 1'b0;
            up.credit  <= 1'b0;
        end
        else
        begin
            if (up.valid)
            begin
                wr_idx <= (wr_idx == AW'(DEPTH - 1)) ? '0 : wr_idx + AW'(1);
            end
            if (send)
            begin
                rd_idx <= (rd_idx == AW'(DEPTH - 1)) ? '0 : rd_idx + AW'(1);
            end
            count      <= count + CNT_W'(up.valid) - CNT_W'(send);
            out_cnt    <= out_cnt - CRED_W'(send) + CRED_W'(down.credit);
            down.valid <= send;
            up.credit  <= send;     // Slot freed upstream together with the send
        end
    end

    always_ff @(posedge clk)
    begin
        if (send)
        begin
            down.ptr  <= head_ptr;
            down.last <= head_last;
        end
    end

    // Upstream must never push beyond the credits it was given
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        up.valid |-> (count < CNT_W'(DEPTH))
    ) else $error("ptr_fifo: push while full, credit protocol breach");

    // Empty buffer has both indices on one slot, so no stale entry is sent
    a_empty_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        (count == '0) |-> (rd_idx == wr_idx)
    ) else $error("ptr_fifo: read index out of step while empty");

endmodule

`default_nettype wire

// ==== ptr_ingress.sv ====
`default_nettype none

module ptr_ingress #(
    parameter int CREDITS = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ptr_valid,
    output logic                ptr_ready,
    input  rowdec_pkg::ptr_t    ptr_data,
    input  logic                ptr_last,
    credit_if.sender            link
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic             accept;

    // A credit is spent on acceptance, so the output register always owns a slot
    assign ptr_ready = (credit_cnt != '0);
    assign accept    = ptr_valid && ptr_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            credit_cnt <= CNT_W'(CREDITS);
            link.valid <= 1'b0;
        end
        else
        begin
            credit_cnt <= credit_cnt - CNT_W'(accept) + CNT_W'(link.credit);
            link.valid <= accept;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            link.ptr  <= ptr_data;
            link.last <= ptr_last;
        end
    end

    // A pointer on the link still owns its credit, so the pool cannot be full
    a_push_has_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        link.valid |-> (credit_cnt < CNT_W'(CREDITS))
    ) else $error("ptr_ingress: credit pool full while a pointer is on the link");

endmodule

`default_nettype wire

// ==== credit_if.sv ====
`default_nettype none

// Pointer link with credit return, no back-pressure on the forward path
interface credit_if;

    logic               valid;      // One pointer pushed this cycle
    rowdec_pkg::ptr_t   ptr;
    logic               last;       // Pointer closes the matrix
    logic               credit;     // One slot returned this cycle

    modport sender (
        output valid,
        output ptr,
        output last,
        input  credit
    );

    modport receiver (
        input  valid,
        input  ptr,
        input  last,
        output credit
    );

endinterface

`default_nettype wire

// ==== rowdec_pkg.sv ====
`default_nettype none

`include "rowdec_params.svh"

package rowdec_pkg;

    // One compressed row pointer
    typedef logic [`ROWDEC_PTR_W-1:0] ptr_t;

    // One decoded row id
    typedef logic [`ROWDEC_ROW_W-1:0] row_id_t;

    typedef logic [`ROWDEC_LANES-1:0] lane_mask_t;   // Contiguous low lanes

    // All lane ids of a beat, lane 0 in the low bits
    typedef logic [`ROWDEC_LANES*`ROWDEC_ROW_W-1:0] id_beat_t;

    // Decoder FSM
    typedef enum logic [1:0] {
        DEC_START,      // Waiting for the base pointer of a matrix
        DEC_WAIT,       // Waiting for the closing pointer of the next row
        DEC_EMIT        // Sending beats of the current row
    } dec_state_t;

endpackage

`default_nettype wire

// ==== rowdec_params.svh ====
`ifndef ROWDEC_PARAMS_SVH
`define ROWDEC_PARAMS_SVH

// Data widths
`define ROWDEC_PTR_W        16
`define ROWDEC_ROW_W        16

// Ids packed per output beat
`define ROWDEC_LANES        4

// Pointer buffer entries, also the ingress credit pool
`define ROWDEC_FIFO_DEPTH   8

// Pointer slots in the decoder, granted as credits to the buffer
`define ROWDEC_DEC_SLOTS    2

`endif
